//--- rtl/id_pkg.sv
// ==========================================================
// Shared types for the RV32 instruction decode stage
// Opcode values, the two instruction views and their union
// Bundles for fetch, register file, write-back and control
// The decode-to-execute bundle and the NOP encoding
// ==========================================================

package id_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  // ==========================================================
  // Base opcodes used by this stage
  // ==========================================================
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_e;

  // Register view, also used for the I, S, B and J immediates
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  // Upper-immediate view for LUI and AUIPC
  typedef struct packed {
    logic [19:0] imm_hi;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  // One fetched word, read through either view
  typedef union packed {
    r_fmt_t r;
    u_fmt_t u;
  } instr_u;

  // ==========================================================
  // Decoded bundles
  // ==========================================================
  typedef struct packed {
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
  } imm_set_t;

  typedef struct packed {
    logic is_load;
    logic load_byte;
    logic load_half;
    logic load_unsigned;
    logic is_store;
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic is_multiply;
    logic is_divide;
    logic is_op;
  } instr_class_t;

  // From fetch and predecode, with the BTB lookup result
  typedef struct packed {
    instr_u          instr;
    logic [XLEN-1:0] pc;
    logic            btb_hit;
    logic            btb_predicted_taken;
    logic [XLEN-1:0] btb_predicted_target;
  } fetch_to_id_t;

  typedef struct packed {
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
  } rf_read_t;

  typedef struct packed {
    logic            write_enable;
    logic [4:0]      rd;
    logic [XLEN-1:0] write_data;
  } wb_write_t;

  // Hazard unit controls, stall wins over flush
  typedef struct packed {
    logic stall;
    logic flush;
  } pipe_ctrl_t;

  typedef struct packed {
    instr_u          instr;
    logic [XLEN-1:0] pc;
    instr_class_t    cls;
    imm_set_t        imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            rs1_is_x0;
    logic            rs2_is_x0;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jal_target;
    logic            btb_hit;
    logic            btb_predicted_taken;
    logic            btb_correct_non_jalr;
  } id_to_ex_t;

  // ADDI x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSTR = {12'd0, 5'd0, 3'd0, 5'd0, OPC_OP_IMM};

endpackage : id_pkg

//--- rtl/id_imm_gen.sv
// ==========================================================
// Immediate generator for the I, S, B, U and J formats
// Sign-extended to XLEN, purely combinational
// ==========================================================

module id_imm_gen
  import id_pkg::*;
(
  input  instr_u   i_instr,
  output imm_set_t o_imm
);

  r_fmt_t r;
  u_fmt_t u;
  logic   sign;

  // Same word, two views
  assign r = i_instr.r;
  assign u = i_instr.u;

  // Bit 31 is the sign for every signed format
  assign sign = r.funct7[6];

  // I format, imm[11:0] sits in funct7 and rs2
  assign o_imm.imm_i = {{20{sign}}, r.funct7, r.rs2};

  // S format, upper part in funct7 and lower part in the rd slot
  assign o_imm.imm_s = {{20{sign}}, r.funct7, r.rd};

  // B format
  // imm[11] comes from rd[0], imm[4:1] from rd[4:1]
  assign o_imm.imm_b = {{20{sign}}, r.rd[0], r.funct7[5:0], r.rd[4:1], 1'b0};

  // U format, low twelve bits are zero
  assign o_imm.imm_u = {u.imm_hi, 12'h000};

  // J format
  // imm[19:12] is the rs1 and funct3 slot, imm[11] is rs2[0]
  // imm[10:1] spans funct7[5:0] and rs2[4:1]
  assign o_imm.imm_j = {
    {12{sign}},
    r.rs1,
    r.funct3,
    r.rs2[0],
    r.funct7[5:0],
    r.rs2[4:1],
    1'b0
  };

endmodule : id_imm_gen

//--- rtl/id_class_decode.sv
// ==========================================================
// Instruction class decoder
// Load size qualifiers, store, branch, jumps, M extension
// and plain register-register ALU operations
// ==========================================================

module id_class_decode
  import id_pkg::*;
(
  input  instr_u       i_instr,
  output instr_class_t o_cls
);

  r_fmt_t r;
  logic   is_load;
  logic   is_reg_op;
  logic   is_m_ext;

  assign r = i_instr.r;

  // ==========================================================
  // Opcode level
  // ==========================================================
  assign is_load   = (r.opcode == OPC_LOAD);
  assign is_reg_op = (r.opcode == OPC_OP);

  // M extension shares the OP opcode, funct7 = 0000001
  assign is_m_ext = is_reg_op && (r.funct7 == 7'b0000001);

  // ==========================================================
  // Class flags
  // ==========================================================
  assign o_cls.is_load = is_load;

  // LB / LBU
  assign o_cls.load_byte = is_load && ((r.funct3 == 3'b000) || (r.funct3 == 3'b100));
  // LH / LHU
  assign o_cls.load_half = is_load && ((r.funct3 == 3'b001) || (r.funct3 == 3'b101));
  // Zero extension for LBU and LHU
  assign o_cls.load_unsigned = is_load && r.funct3[2];

  assign o_cls.is_store  = (r.opcode == OPC_STORE);
  assign o_cls.is_branch = (r.opcode == OPC_BRANCH);
  assign o_cls.is_jal    = (r.opcode == OPC_JAL);

  // JALR is only defined with funct3 = 000
  assign o_cls.is_jalr = (r.opcode == OPC_JALR) && (r.funct3 == 3'b000);

  // MUL, MULH, MULHSU, MULHU have funct3[2] clear
  assign o_cls.is_multiply = is_m_ext && !r.funct3[2];
  // DIV, DIVU, REM, REMU
  assign o_cls.is_divide = is_m_ext && r.funct3[2];

  // Base integer register-register op only
  assign o_cls.is_op = is_reg_op && !is_m_ext;

endmodule : id_class_decode

//--- rtl/id_target_calc.sv
// ==========================================================
// PC-relative target precompute
// Branch and JAL targets, BTB check for non-JALR control flow
// ==========================================================

module id_target_calc
  import id_pkg::*;
(
  input  logic [XLEN-1:0] i_pc,
  input  imm_set_t        i_imm,
  input  logic            i_is_jal,
  input  logic [XLEN-1:0] i_btb_target,
  output logic [XLEN-1:0] o_branch_target,
  output logic [XLEN-1:0] o_jal_target,
  output logic            o_btb_correct_non_jalr
);

  logic [XLEN-1:0] sel_target;

  // Immediates are already sign-extended to full width
  assign o_branch_target = i_pc + i_imm.imm_b;
  assign o_jal_target    = i_pc + i_imm.imm_j;

  // Target the BTB should have predicted for this instruction
  assign sel_target = i_is_jal ? o_jal_target : o_branch_target;

  // Only meaningful for JAL and branches, JALR is checked in execute
  assign o_btb_correct_non_jalr = (sel_target == i_btb_target);

endmodule : id_target_calc

//--- rtl/id_wb_bypass.sv
// ==========================================================
// Write-back bypass for register file read data
// Flags source registers that are x0
// ==========================================================

module id_wb_bypass
  import id_pkg::*;
(
  input  logic [4:0] i_rs1_addr,
  input  logic [4:0] i_rs2_addr,
  input  rf_read_t   i_rf,
  input  wb_write_t  i_wb,
  output rf_read_t   o_rf,
  output logic       o_rs1_is_x0,
  output logic       o_rs2_is_x0
);

  logic wb_live;
  logic hit_rs1;
  logic hit_rs2;

  // Register file writes at the edge, so a read in the same cycle is stale
  // Writes to x0 are dropped and must never be forwarded
  assign wb_live = i_wb.write_enable && (i_wb.rd != 5'd0);

  assign hit_rs1 = wb_live && (i_wb.rd == i_rs1_addr);
  assign hit_rs2 = wb_live && (i_wb.rd == i_rs2_addr);

  // Each source picks its own data independently
  assign o_rf.rs1_data = hit_rs1 ? i_wb.write_data : i_rf.rs1_data;
  assign o_rf.rs2_data = hit_rs2 ? i_wb.write_data : i_rf.rs2_data;

  // Lets the forwarding logic in execute skip x0 sources
  assign o_rs1_is_x0 = (i_rs1_addr == 5'd0);
  assign o_rs2_is_x0 = (i_rs2_addr == 5'd0);

endmodule : id_wb_bypass

//--- rtl/id_ex_reg.sv
// ==========================================================
// Decode to execute pipeline register
// Async reset on control fields, stall holds, flush bubbles
// ==========================================================

module id_ex_reg
  import id_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  pipe_ctrl_t i_ctrl,
  input  id_to_ex_t  i_next,
  output id_to_ex_t  o_q
);

  id_to_ex_t load_val;

  // Control state
  instr_u          instr_q;
  logic [XLEN-1:0] pc_q;
  instr_class_t    cls_q;
  logic            rs1_is_x0_q;
  logic            rs2_is_x0_q;
  logic            btb_hit_q;
  logic            btb_taken_q;
  logic            btb_ok_q;

  // Datapath payload
  imm_set_t        imm_q;
  logic [XLEN-1:0] rs1_data_q;
  logic [XLEN-1:0] rs2_data_q;
  logic [XLEN-1:0] branch_target_q;
  logic [XLEN-1:0] jal_target_q;

  // ==========================================================
  // Flush turns the incoming bundle into a bubble
  // ==========================================================
  always_comb begin
    load_val = i_next;
    if (i_ctrl.flush) begin
      load_val.instr                = NOP_INSTR;
      load_val.cls                  = '0;
      load_val.btb_hit              = 1'b0;
      load_val.btb_predicted_taken  = 1'b0;
      load_val.btb_correct_non_jalr = 1'b0;
    end
  end

  // Reset presents a NOP with both sources as x0
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      instr_q     <= NOP_INSTR;
      pc_q        <= '0;
      cls_q       <= '0;
      rs1_is_x0_q <= 1'b1;
      rs2_is_x0_q <= 1'b1;
      btb_hit_q   <= 1'b0;
      btb_taken_q <= 1'b0;
      btb_ok_q    <= 1'b0;
    end else if (!i_ctrl.stall) begin
      instr_q     <= load_val.instr;
      pc_q        <= load_val.pc;
      cls_q       <= load_val.cls;
      rs1_is_x0_q <= load_val.rs1_is_x0;
      rs2_is_x0_q <= load_val.rs2_is_x0;
      btb_hit_q   <= load_val.btb_hit;
      btb_taken_q <= load_val.btb_predicted_taken;
      btb_ok_q    <= load_val.btb_correct_non_jalr;
    end
  end

  // Payload follows stall only
  always_ff @(posedge i_clk) begin
    if (!i_ctrl.stall) begin
      imm_q           <= i_next.imm;
      rs1_data_q      <= i_next.rs1_data;
      rs2_data_q      <= i_next.rs2_data;
      branch_target_q <= i_next.branch_target;
      jal_target_q    <= i_next.jal_target;
    end
  end

  assign o_q = '{
    instr:                instr_q,
    pc:                   pc_q,
    cls:                  cls_q,
    imm:                  imm_q,
    rs1_data:             rs1_data_q,
    rs2_data:             rs2_data_q,
    rs1_is_x0:            rs1_is_x0_q,
    rs2_is_x0:            rs2_is_x0_q,
    branch_target:        branch_target_q,
    jal_target:           jal_target_q,
    btb_hit:              btb_hit_q,
    btb_predicted_taken:  btb_taken_q,
    btb_correct_non_jalr: btb_ok_q
  };

endmodule : id_ex_reg

//--- rtl/id_stage.sv
// ==========================================================
// Instruction decode stage, top level
// Immediates, class flags, targets and WB bypass feed
// one registered bundle for the execute stage
// ==========================================================

module id_stage
  import id_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst_n,
  input  pipe_ctrl_t   i_ctrl,
  input  fetch_to_id_t i_fetch,
  input  rf_read_t     i_rf,
  input  wb_write_t    i_wb,
  output id_to_ex_t    o_id_to_ex
);

  imm_set_t        imm;
  instr_class_t    cls;
  rf_read_t        rf_fwd;
  logic            rs1_is_x0;
  logic            rs2_is_x0;
  logic [XLEN-1:0] branch_target;
  logic [XLEN-1:0] jal_target;
  logic            btb_correct;
  id_to_ex_t       next_bundle;

  // ==========================================================
  // Combinational decode
  // ==========================================================
  id_imm_gen u_imm_gen (
    .i_instr (i_fetch.instr),
    .o_imm   (imm)
  );

  id_class_decode u_class_decode (
    .i_instr (i_fetch.instr),
    .o_cls   (cls)
  );

  id_target_calc u_target_calc (
    .i_pc                   (i_fetch.pc),
    .i_imm                  (imm),
    .i_is_jal               (cls.is_jal),
    .i_btb_target           (i_fetch.btb_predicted_target),
    .o_branch_target        (branch_target),
    .o_jal_target           (jal_target),
    .o_btb_correct_non_jalr (btb_correct)
  );

  // Source addresses come straight from the fetched word
  id_wb_bypass u_wb_bypass (
    .i_rs1_addr  (i_fetch.instr.r.rs1),
    .i_rs2_addr  (i_fetch.instr.r.rs2),
    .i_rf        (i_rf),
    .i_wb        (i_wb),
    .o_rf        (rf_fwd),
    .o_rs1_is_x0 (rs1_is_x0),
    .o_rs2_is_x0 (rs2_is_x0)
  );

  // ==========================================================
  // Bundle assembly and pipeline register
  // ==========================================================
  assign next_bundle = '{
    instr:                i_fetch.instr,
    pc:                   i_fetch.pc,
    cls:                  cls,
    imm:                  imm,
    rs1_data:             rf_fwd.rs1_data,
    rs2_data:             rf_fwd.rs2_data,
    rs1_is_x0:            rs1_is_x0,
    rs2_is_x0:            rs2_is_x0,
    branch_target:        branch_target,
    jal_target:           jal_target,
    btb_hit:              i_fetch.btb_hit,
    btb_predicted_taken:  i_fetch.btb_predicted_taken,
    btb_correct_non_jalr: btb_correct
  };

  id_ex_reg u_id_ex_reg (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ctrl  (i_ctrl),
    .i_next  (next_bundle),
    .o_q     (o_id_to_ex)
  );

endmodule : id_stage

//--- tests/tb_id_stage.sv
// ==========================================================
// Testbench for the instruction decode stage
// Clock, reset, watchdog, instruction encoders
// Compare tasks and six directed tests
// ==========================================================

module tb_id_stage
  import id_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int NUM_TESTS  = 6;
  // ADDI x0, x0, 0 as encoded by the ISA
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  logic         i_clk;
  logic         i_rst_n;
  pipe_ctrl_t   i_ctrl;
  fetch_to_id_t i_fetch;
  rf_read_t     i_rf;
  wb_write_t    i_wb;
  id_to_ex_t    o_id_to_ex;

  int errors;
  int checks;

  id_stage dut0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_ctrl     (i_ctrl),
    .i_fetch    (i_fetch),
    .i_rf       (i_rf),
    .i_wb       (i_wb),
    .o_id_to_ex (o_id_to_ex)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // Generous bound, about 40 cycles per test
  initial begin
    #(NUM_TESTS * 40 * CLK_PERIOD);
    $display("Timeout: the tests did not finish in time");
    $display("Errors found");
    $finish;
  end

  // ==========================================================
  // Instruction encoders, fields placed as in the ISA manual
  // ==========================================================
  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] hi, logic [4:0] rd);
    return {hi, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // ==========================================================
  // Stimulus and compare helpers
  // ==========================================================
  task automatic present(logic [31:0] word, logic [31:0] pc, logic hit, logic taken,
                         logic [31:0] target);
    i_fetch.instr                = word;
    i_fetch.pc                   = pc;
    i_fetch.btb_hit              = hit;
    i_fetch.btb_predicted_taken  = taken;
    i_fetch.btb_predicted_target = target;
  endtask

  // Inputs change on the falling edge, outputs are read one falling edge later
  task automatic next_cycle();
    @(posedge i_clk);
    @(negedge i_clk);
  endtask

  task automatic word_check(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %h got %h", name, exp, act);
    end
  endtask

  // Care mask selects the immediate fields that this instruction defines
  task automatic imm_check(string name, imm_set_t exp, imm_set_t act, imm_set_t care);
    checks++;
    if ((exp & care) !== (act & care)) begin
      errors++;
      $display("[ERROR] %s expected %h got %h", name, exp & care, act & care);
    end
  endtask

  task automatic cls_check(string name, instr_class_t exp, instr_class_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic rf_check(string name, rf_read_t exp, rf_read_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic finish_test(string name, int errs_before);
    if (errors == errs_before)
      $display("%s: passed", name);
    else
      $display("%s: %0d mismatches", name, errors - errs_before);
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================
  task automatic reset_values();
    int e0;
    e0 = errors;
    word_check("instr", NOP_WORD, o_id_to_ex.instr);
    word_check("pc", 32'd0, o_id_to_ex.pc);
    cls_check("cls", '0, o_id_to_ex.cls);
    word_check("btb_hit", 32'd0, {31'd0, o_id_to_ex.btb_hit});
    word_check("btb_predicted_taken", 32'd0, {31'd0, o_id_to_ex.btb_predicted_taken});
    word_check("btb_correct_non_jalr", 32'd0, {31'd0, o_id_to_ex.btb_correct_non_jalr});
    word_check("rs1_is_x0", 32'd1, {31'd0, o_id_to_ex.rs1_is_x0});
    word_check("rs2_is_x0", 32'd1, {31'd0, o_id_to_ex.rs2_is_x0});
    finish_test("reset values", e0);
  endtask

  // Field 0..4 selects imm_i, imm_s, imm_b, imm_u, imm_j
  task automatic imm_case(string name, logic [31:0] word, int field, logic [31:0] value);
    imm_set_t exp;
    imm_set_t care;
    exp  = {5{value}};
    care = '0;
    case (field)
      0: care.imm_i = '1;
      1: care.imm_s = '1;
      2: care.imm_b = '1;
      3: care.imm_u = '1;
      default: care.imm_j = '1;
    endcase
    present(word, 32'h0000_1000, 1'b0, 1'b0, 32'd0);
    next_cycle();
    imm_check(name, exp, o_id_to_ex.imm, care);
  endtask

  task automatic immediate_formats();
    int e0;
    e0 = errors;
    imm_case("imm_i ADDI", i_type(12'hFFB, 5'd2, 3'b000, 5'd1, OPC_OP_IMM), 0, 32'hFFFF_FFFB);
    imm_case("imm_s SW", s_type(12'hFF8, 5'd3, 5'd4), 1, 32'hFFFF_FFF8);
    imm_case("imm_b BEQ", b_type(13'h19A4, 5'd2, 5'd1), 2, 32'hFFFF_F9A4);
    imm_case("imm_u LUI", u_type(20'hDEADB, 5'd5), 3, 32'hDEAD_B000);
    imm_case("imm_j JAL", j_type(21'h0A_5F3C, 5'd1), 4, 32'h000A_5F3C);
    finish_test("immediate formats", e0);
  endtask

  task automatic cls_case(string name, logic [31:0] word, instr_class_t exp);
    present(word, 32'h0000_2000, 1'b0, 1'b0, 32'd0);
    next_cycle();
    cls_check(name, exp, o_id_to_ex.cls);
  endtask

  task automatic class_flags();
    int e0;
    e0 = errors;
    cls_case("cls LB", i_type(12'd4, 5'd1, 3'b000, 5'd2, OPC_LOAD),
             '{is_load: 1'b1, load_byte: 1'b1, default: 1'b0});
    cls_case("cls LHU", i_type(12'd6, 5'd1, 3'b101, 5'd2, OPC_LOAD),
             '{is_load: 1'b1, load_half: 1'b1, load_unsigned: 1'b1, default: 1'b0});
    cls_case("cls LW", i_type(12'd8, 5'd1, 3'b010, 5'd2, OPC_LOAD),
             '{is_load: 1'b1, default: 1'b0});
    cls_case("cls MUL", r_type(7'd1, 5'd3, 5'd2, 3'b000, 5'd1, OPC_OP),
             '{is_multiply: 1'b1, default: 1'b0});
    cls_case("cls DIVU", r_type(7'd1, 5'd3, 5'd2, 3'b101, 5'd1, OPC_OP),
             '{is_divide: 1'b1, default: 1'b0});
    cls_case("cls ADD", r_type(7'd0, 5'd3, 5'd2, 3'b000, 5'd1, OPC_OP),
             '{is_op: 1'b1, default: 1'b0});
    cls_case("cls JAL", j_type(21'd16, 5'd1), '{is_jal: 1'b1, default: 1'b0});
    cls_case("cls JALR", i_type(12'd0, 5'd1, 3'b000, 5'd0, OPC_JALR),
             '{is_jalr: 1'b1, default: 1'b0});
    finish_test("class flags", e0);
  endtask

  // ADD x7, x6, x5 unless both sources are x0
  // fwd_rs1 and fwd_rs2 name the sources that should see the write-back data
  task automatic bypass_case(string name, logic x0_srcs, logic we, logic [4:0] rd,
                             logic fwd_rs1, logic fwd_rs2);
    rf_read_t    rfv;
    logic [31:0] wdata;
    rf_read_t    exp;
    rfv.rs1_data = $urandom;
    rfv.rs2_data = $urandom;
    wdata        = $urandom;
    exp          = rfv;
    if (x0_srcs)
      present(r_type(7'd0, 5'd0, 5'd0, 3'b000, 5'd7, OPC_OP), 32'h100, 1'b0, 1'b0, 32'd0);
    else
      present(r_type(7'd0, 5'd5, 5'd6, 3'b000, 5'd7, OPC_OP), 32'h100, 1'b0, 1'b0, 32'd0);
    i_rf = rfv;
    i_wb = '{write_enable: we, rd: rd, write_data: wdata};
    if (fwd_rs1)
      exp.rs1_data = wdata;
    if (fwd_rs2)
      exp.rs2_data = wdata;
    next_cycle();
    rf_check(name, exp, '{rs1_data: o_id_to_ex.rs1_data, rs2_data: o_id_to_ex.rs2_data});
    word_check({name, " rs1_is_x0"}, {31'd0, x0_srcs}, {31'd0, o_id_to_ex.rs1_is_x0});
    word_check({name, " rs2_is_x0"}, {31'd0, x0_srcs}, {31'd0, o_id_to_ex.rs2_is_x0});
  endtask

  task automatic bypass_paths();
    int e0;
    e0 = errors;
    bypass_case("wb to rs1", 1'b0, 1'b1, 5'd6, 1'b1, 1'b0);
    bypass_case("wb to rs2", 1'b0, 1'b1, 5'd5, 1'b0, 1'b1);
    bypass_case("wb disabled", 1'b0, 1'b0, 5'd6, 1'b0, 1'b0);
    bypass_case("wb to x0", 1'b1, 1'b1, 5'd0, 1'b0, 1'b0);
    i_wb = '0;
    finish_test("write-back bypass", e0);
  endtask

  task automatic target_precompute();
    int          e0;
    logic [31:0] pc;
    logic [31:0] br_tgt;
    logic [31:0] jal_tgt;
    e0      = errors;
    pc      = $urandom & 32'hFFFF_FFFC;
    br_tgt  = pc + 32'hFFFF_F9A4;
    jal_tgt = pc + 32'h000A_5F3C;
    present(b_type(13'h19A4, 5'd2, 5'd1), pc, 1'b1, 1'b1, br_tgt);
    next_cycle();
    word_check("branch_target", br_tgt, o_id_to_ex.branch_target);
    word_check("btb_correct_non_jalr BEQ hit", 32'd1, {31'd0, o_id_to_ex.btb_correct_non_jalr});
    present(b_type(13'h19A4, 5'd2, 5'd1), pc, 1'b1, 1'b1, br_tgt + 32'd4);
    next_cycle();
    word_check("btb_correct_non_jalr BEQ miss", 32'd0, {31'd0, o_id_to_ex.btb_correct_non_jalr});
    present(j_type(21'h0A_5F3C, 5'd1), pc, 1'b1, 1'b1, jal_tgt);
    next_cycle();
    word_check("jal_target", jal_tgt, o_id_to_ex.jal_target);
    word_check("btb_correct_non_jalr JAL hit", 32'd1, {31'd0, o_id_to_ex.btb_correct_non_jalr});
    present(j_type(21'h0A_5F3C, 5'd1), pc, 1'b1, 1'b1, jal_tgt + 32'd4);
    next_cycle();
    word_check("btb_correct_non_jalr JAL miss", 32'd0, {31'd0, o_id_to_ex.btb_correct_non_jalr});
    finish_test("targets and BTB check", e0);
  endtask

  task automatic stall_and_flush();
    int          e0;
    logic [31:0] add_word;
    logic [31:0] pa;
    logic [31:0] pb;
    e0       = errors;
    add_word = r_type(7'd0, 5'd5, 5'd6, 3'b000, 5'd7, OPC_OP);
    pa       = $urandom & 32'hFFFF_FFFC;
    pb       = pa + 32'd64;
    present(add_word, pa, 1'b1, 1'b1, 32'd0);
    next_cycle();
    // Held for two edges while the input moves on
    // The JAL has every BTB flag set, so the bubble has something to clear
    i_ctrl = '{stall: 1'b1, flush: 1'b0};
    present(j_type(21'd32, 5'd1), pb, 1'b1, 1'b1, pb + 32'd32);
    next_cycle();
    next_cycle();
    word_check("stall instr", add_word, o_id_to_ex.instr);
    word_check("stall pc", pa, o_id_to_ex.pc);
    cls_check("stall cls", '{is_op: 1'b1, default: 1'b0}, o_id_to_ex.cls);
    word_check("stall btb_hit", 32'd1, {31'd0, o_id_to_ex.btb_hit});
    // ADD x7, x6, x5 puts 5 in the I immediate slot
    word_check("stall imm_i", 32'd5, o_id_to_ex.imm.imm_i);
    // Bubble, while pc still loads
    i_ctrl = '{stall: 1'b0, flush: 1'b1};
    next_cycle();
    word_check("flush instr", NOP_WORD, o_id_to_ex.instr);
    word_check("flush pc", pb, o_id_to_ex.pc);
    word_check("flush jal_target", pb + 32'd32, o_id_to_ex.jal_target);
    cls_check("flush cls", '0, o_id_to_ex.cls);
    word_check("flush btb_hit", 32'd0, {31'd0, o_id_to_ex.btb_hit});
    word_check("flush btb_predicted_taken", 32'd0, {31'd0, o_id_to_ex.btb_predicted_taken});
    word_check("flush btb_correct", 32'd0, {31'd0, o_id_to_ex.btb_correct_non_jalr});
    i_ctrl = '{stall: 1'b1, flush: 1'b1};
    present(add_word, pa, 1'b1, 1'b1, 32'd0);
    next_cycle();
    word_check("stall+flush instr", NOP_WORD, o_id_to_ex.instr);
    word_check("stall+flush pc", pb, o_id_to_ex.pc);
    i_ctrl = '0;
    finish_test("stall and flush", e0);
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    void'($urandom(90));
    errors   = 0;
    checks   = 0;
    i_rst_n  = 1'b0;
    // Stall keeps the register at its reset value after release
    i_ctrl   = '{stall: 1'b1, flush: 1'b0};
    i_fetch  = '0;
    i_rf     = '0;
    i_wb     = '0;
    repeat (5) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    reset_values();
    i_ctrl = '0;
    immediate_formats();
    class_flags();
    bypass_paths();
    target_precompute();
    stall_and_flush();
    $display("tests=%0d checks=%0d mismatches=%0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : tb_id_stage

//--- id_stage.f
rtl/id_pkg.sv
rtl/id_imm_gen.sv
rtl/id_class_decode.sv
rtl/id_target_calc.sv
rtl/id_wb_bypass.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
tests/tb_id_stage.sv

//--- Makefile
# Verilator build and run for the decode stage testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= id_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
